// File: Bender.yml
package:
  name: cart_ctrl

sources:
  - mcu_cmd_pkg.sv
  - spi_pkg.sv
  - spi_link_if.sv
  - mem_bus_if.sv
  - spi_slave.sv
  - mcu_cmd.sv
  - save_ram.sv
  - cart_ctrl_top.sv
  - target: test
    files:
      - cart_ctrl_props.sv
      - tb_cart_ctrl.sv

// File: cart_ctrl_props.sv
`timescale 1ns/100ps

module cart_ctrl_props (
   input logic clk,
   input logic arst_n,
   input logic rd,
   input logic wr,
   input logic cmd_ready,
   input logic param_ready
);

   // One memory access at a time
   rd_wr_exclusive : assert property (@(posedge clk) disable iff (!arst_n) !(rd && wr))
      else $error("rd and wr are high in the same cycle");

   // A byte is either the command or a parameter
   strobe_exclusive : assert property (@(posedge clk) disable iff (!arst_n)
      !(cmd_ready && param_ready))
      else $error("cmd_ready and param_ready are high in the same cycle");

   // Memory bus quiet in reset
   idle_in_reset : assert property (@(posedge clk) !arst_n |-> (!rd && !wr))
      else $error("rd or wr is high while arst_n is low");

endmodule

bind mcu_cmd cart_ctrl_props i_props (
   .clk         (clk),
   .arst_n      (arst_n),
   .rd          (mem.rd),
   .wr          (mem.wr),
   .cmd_ready   (link.cmd_ready),
   .param_ready (link.param_ready)
);

// File: cart_ctrl_top.sv
`timescale 1ns/100ps

module cart_ctrl_top #(
   parameter int ADDR_WIDTH = mcu_cmd_pkg::addr_width,
   parameter int DEPTH_LOG2 = 8
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  sck,
   input  logic                  mosi,
   input  logic                  ss_n,
   output logic                  miso,
   output logic [3:0]            mapper,
   output logic [ADDR_WIDTH-1:0] rom_mask,
   output logic [ADDR_WIDTH-1:0] save_mask,
   output logic [ADDR_WIDTH-1:0] mem_addr
);

   spi_link_if link ();
   mem_bus_if #(.ADDR_WIDTH(ADDR_WIDTH)) mem ();

   spi_slave i_spi_slave (
      .clk    (clk),
      .arst_n (arst_n),
      .sck    (sck),
      .mosi   (mosi),
      .ss_n   (ss_n),
      .miso   (miso),
      .link   (link.producer)
   );

   mcu_cmd #(.ADDR_WIDTH(ADDR_WIDTH)) i_mcu_cmd (
      .clk       (clk),
      .arst_n    (arst_n),
      .link      (link.consumer),
      .mem       (mem.master),
      .mapper    (mapper),
      .rom_mask  (rom_mask),
      .save_mask (save_mask),
      .mem_addr  (mem_addr)
   );

   save_ram #(
      .DEPTH_LOG2 (DEPTH_LOG2),
      .ADDR_WIDTH (ADDR_WIDTH)
   ) i_save_ram (
      .clk       (clk),
      .arst_n    (arst_n),
      .mem       (mem.slave),
      .save_mask (save_mask)
   );

endmodule

// File: compile.f
mcu_cmd_pkg.sv
spi_pkg.sv
spi_link_if.sv
mem_bus_if.sv
spi_slave.sv
mcu_cmd.sv
save_ram.sv
cart_ctrl_top.sv
cart_ctrl_props.sv
tb_cart_ctrl.sv

// File: mcu_cmd.sv
`timescale 1ns/100ps

module mcu_cmd #(
   parameter int ADDR_WIDTH = mcu_cmd_pkg::addr_width
) (
   input  logic                  clk,
   input  logic                  arst_n,
   spi_link_if.consumer          link,
   mem_bus_if.master             mem,
   output logic [3:0]            mapper,
   output logic [ADDR_WIDTH-1:0] rom_mask,
   output logic [ADDR_WIDTH-1:0] save_mask,
   output logic [ADDR_WIDTH-1:0] mem_addr
);

   mcu_cmd_pkg::cmd_op_e  op;
   logic                  strobe;
   logic                  auto_inc;
   logic                  between_bytes;
   logic                  rd_q;
   logic                  rd_d;
   logic                  wr_q;
   logic [7:0]            wdata_q;
   logic [7:0]            tx_q;
   logic [ADDR_WIDTH-1:0] addr_q;

   // Bytes 2..4 of a frame fill a word from the top down
   function automatic logic [ADDR_WIDTH-1:0] put_byte(
      input logic [ADDR_WIDTH-1:0]              word,
      input logic [spi_pkg::byte_cnt_width-1:0] cnt,
      input logic [7:0]                         data
   );
      logic [ADDR_WIDTH-1:0] res;
      res = word;
      case (cnt)
         2: res[23:16] = data;
         3: res[15:8]  = data;
         4: res[7:0]   = data;
         default: res = word;
      endcase
      return res;
   endfunction

   assign op            = mcu_cmd_pkg::cmd_op_e'(link.cmd_data[7:4]);
   assign strobe        = link.cmd_ready || link.param_ready;
   assign auto_inc      = link.cmd_data[0];
   assign between_bytes = (link.bit_cnt == '0);

   //////////////////////////////////////////////////
   // Mapper, masks and address
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mapper    <= '0;
         rom_mask  <= mcu_cmd_pkg::mask_reset;
         save_mask <= mcu_cmd_pkg::mask_reset;
         addr_q    <= '0;
      end else begin
         if (link.cmd_ready && op == mcu_cmd_pkg::set_mapper) begin
            mapper <= link.cmd_data[3:0];
         end
         // Step after each completed access
         if (auto_inc && (wr_q || rd_d)) begin
            addr_q <= addr_q + 1'b1;
         end
         if (link.param_ready) begin
            case (op)
               mcu_cmd_pkg::set_addr: begin
                  // First address byte also clears the rest
                  addr_q <= put_byte((link.byte_cnt == 2) ? '0 : addr_q,
                                     link.byte_cnt, link.param_data);
               end
               mcu_cmd_pkg::set_rom_mask: begin
                  rom_mask <= put_byte(rom_mask, link.byte_cnt, link.param_data);
               end
               mcu_cmd_pkg::set_save_mask: begin
                  save_mask <= put_byte(save_mask, link.byte_cnt, link.param_data);
               end
               default: ;
            endcase
         end
      end
   end

   //////////////////////////////////////////////////
   // Read and write pulses, reply byte
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_q <= 1'b0;
         rd_d <= 1'b0;
         wr_q <= 1'b0;
         tx_q <= '0;
      end else begin
         rd_q <= strobe && (op == mcu_cmd_pkg::mem_read);
         wr_q <= link.param_ready && (link.byte_cnt >= 2) &&
                 (op == mcu_cmd_pkg::mem_write);
         // rdata lands one cycle after rd
         rd_d <= rd_q;
         // Reply only changes while the shifter sits between bytes
         if (between_bytes) begin
            if (strobe && op == mcu_cmd_pkg::echo) begin
               tx_q <= mcu_cmd_pkg::echo_byte;
            end else if (rd_d) begin
               tx_q <= mem.rdata;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (link.param_ready && op == mcu_cmd_pkg::mem_write) begin
         wdata_q <= link.param_data;
      end
   end

   assign mem.addr     = addr_q;
   assign mem.rd       = rd_q;
   assign mem.wr       = wr_q;
   assign mem.wdata    = wdata_q;
   assign mem_addr     = addr_q;
   assign link.tx_data = tx_q;

endmodule

// File: mcu_cmd_pkg.sv
package mcu_cmd_pkg;

   // Address and mask width
   localparam int addr_width = 24;

   //////////////////////////////////////////////////
   // Command opcodes, upper nibble of command byte
   //////////////////////////////////////////////////
   typedef enum logic [3:0] {
      set_addr      = 4'h0,
      set_rom_mask  = 4'h1,
      set_save_mask = 4'h2,
      set_mapper    = 4'h3,
      mem_read      = 4'h8,
      mem_write     = 4'h9,
      echo          = 4'hF
   } cmd_op_e;

   // Reply byte for the echo command
   localparam logic [7:0] echo_byte = 8'hA5;

   // Masks come up fully open
   localparam logic [addr_width-1:0] mask_reset = '1;

endpackage

// File: mem_bus_if.sv
`timescale 1ns/100ps

interface mem_bus_if #(
   parameter int ADDR_WIDTH = mcu_cmd_pkg::addr_width
);

   logic [ADDR_WIDTH-1:0] addr;
   logic                  rd;
   logic                  wr;
   logic [7:0]            wdata;
   // Valid one cycle after rd
   logic [7:0]            rdata;

   modport master (
      output addr, rd, wr, wdata,
      input  rdata
   );

   modport slave (
      input  addr, rd, wr, wdata,
      output rdata
   );

endinterface

// File: save_ram.sv
`timescale 1ns/100ps

module save_ram #(
   parameter int DEPTH_LOG2 = 8,
   parameter int ADDR_WIDTH = mcu_cmd_pkg::addr_width
) (
   input  logic                  clk,
   input  logic                  arst_n,
   mem_bus_if.slave              mem,
   input  logic [ADDR_WIDTH-1:0] save_mask
);

   logic [7:0]            ram [2**DEPTH_LOG2];
   logic [ADDR_WIDTH-1:0] masked_addr;
   logic [DEPTH_LOG2-1:0] word_addr;
   logic [7:0]            rdata_q;

   // Mask folds the save area onto the physical depth
   assign masked_addr = mem.addr & save_mask;
   assign word_addr   = masked_addr[DEPTH_LOG2-1:0];

   always_ff @(posedge clk) begin
      if (mem.wr) begin
         ram[word_addr] <= mem.wdata;
      end
   end

   // Registered read, one cycle latency
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdata_q <= '0;
      end else if (mem.rd) begin
         rdata_q <= ram[word_addr];
      end
   end

   assign mem.rdata = rdata_q;

endmodule

// File: spi_link_if.sv
`timescale 1ns/100ps

interface spi_link_if;

   logic                                cmd_ready;
   logic                                param_ready;
   spi_pkg::spi_byte_t                  cmd_data;
   spi_pkg::spi_byte_t                  param_data;
   logic [spi_pkg::byte_cnt_width-1:0]  byte_cnt;
   logic [spi_pkg::bit_cnt_width-1:0]   bit_cnt;
   // Reply byte for the next SPI byte
   spi_pkg::spi_byte_t                  tx_data;

   modport producer (
      output cmd_ready, param_ready, cmd_data, param_data, byte_cnt, bit_cnt,
      input  tx_data
   );

   modport consumer (
      input  cmd_ready, param_ready, cmd_data, param_data, byte_cnt, bit_cnt,
      output tx_data
   );

endinterface

// File: spi_pkg.sv
package spi_pkg;

   // One byte on the wire
   typedef logic [7:0] spi_byte_t;

   // Bit position within a byte
   localparam int bit_cnt_width = 3;

   // Bytes per frame, saturating
   localparam int byte_cnt_width = 8;

   // Receiver phase, follows ss_n
   typedef enum logic {
      idle,
      active
   } spi_phase_e;

endpackage

// File: spi_slave.sv
`timescale 1ns/100ps

module spi_slave (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         sck,
   input  logic         mosi,
   input  logic         ss_n,
   output logic         miso,
   spi_link_if.producer link
);

   logic [1:0]                         sck_sync;
   logic [1:0]                         ss_sync;
   logic [1:0]                         mosi_sync;
   logic                               sck_d;
   logic                               ss_d;
   logic                               sck_rise;
   logic                               sck_fall;
   logic                               ss_fall;
   logic                               byte_done;
   spi_pkg::spi_phase_e                phase;
   spi_pkg::spi_byte_t                 rx_shift;
   spi_pkg::spi_byte_t                 rx_byte;
   spi_pkg::spi_byte_t                 tx_shift;
   spi_pkg::spi_byte_t                 cmd_q;
   spi_pkg::spi_byte_t                 param_q;
   logic [spi_pkg::bit_cnt_width-1:0]  bit_cnt;
   logic [spi_pkg::byte_cnt_width-1:0] byte_cnt;
   logic                               cmd_ready_q;
   logic                               param_ready_q;

   //////////////////////////////////////////////////
   // Pin synchronizers and edge detection
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sck_sync  <= '0;
         ss_sync   <= '1;
         mosi_sync <= '0;
         sck_d     <= 1'b0;
         ss_d      <= 1'b1;
      end else begin
         sck_sync  <= {sck_sync[0], sck};
         ss_sync   <= {ss_sync[0], ss_n};
         mosi_sync <= {mosi_sync[0], mosi};
         sck_d     <= sck_sync[1];
         ss_d      <= ss_sync[1];
      end
   end

   assign ss_fall   = !ss_sync[1] && ss_d;
   assign sck_rise  = (phase == spi_pkg::active) && sck_sync[1] && !sck_d;
   assign sck_fall  = (phase == spi_pkg::active) && !sck_sync[1] && sck_d;
   assign rx_byte   = {rx_shift[6:0], mosi_sync[1]};
   assign byte_done = sck_rise && (bit_cnt == '1);

   //////////////////////////////////////////////////
   // Frame tracking, counters and strobes
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase         <= spi_pkg::idle;
         bit_cnt       <= '0;
         byte_cnt      <= '0;
         cmd_ready_q   <= 1'b0;
         param_ready_q <= 1'b0;
         cmd_q         <= '0;
         tx_shift      <= '0;
      end else begin
         if (ss_fall) begin
            phase <= spi_pkg::active;
         end else if (ss_sync[1]) begin
            phase <= spi_pkg::idle;
         end
         if (ss_fall) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            // Saturate on very long frames
            if (byte_done && byte_cnt != '1) begin
               byte_cnt <= byte_cnt + 1'b1;
            end
         end
         cmd_ready_q   <= byte_done && (byte_cnt == '0);
         param_ready_q <= byte_done && (byte_cnt != '0);
         if (byte_done && byte_cnt == '0) begin
            cmd_q <= rx_byte;
         end
         // MSB out right away, next reply picked up on the fall that ends a byte
         if (ss_fall) begin
            tx_shift <= link.tx_data;
         end else if (sck_fall) begin
            if (bit_cnt == '0) begin
               tx_shift <= link.tx_data;
            end else begin
               tx_shift <= {tx_shift[6:0], 1'b0};
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sck_rise) begin
         rx_shift <= rx_byte;
      end
      if (byte_done) begin
         param_q <= rx_byte;
      end
   end

   assign miso             = tx_shift[7];
   assign link.cmd_ready   = cmd_ready_q;
   assign link.param_ready = param_ready_q;
   assign link.cmd_data    = cmd_q;
   assign link.param_data  = param_q;
   assign link.byte_cnt    = byte_cnt;
   assign link.bit_cnt     = bit_cnt;

endmodule

// File: tb_cart_ctrl.sv
`timescale 1ns/100ps

module tb_cart_ctrl;

   localparam int half_cycles  = 8;
   localparam int byte_cycles  = 16 * half_cycles;
   localparam int frame_cycles = 32;
   localparam int n_words      = 6;
   // Bytes and frames sent over all tests
   localparam int num_bytes    = 13 + 8 + (10 + 2 * n_words) + 20 + 10;
   localparam int num_frames   = 19;
   localparam int timeout_cycles =
      2 * (num_bytes * byte_cycles + num_frames * frame_cycles) + 100;

   logic                               clk;
   logic                               arst_n;
   logic                               sck;
   logic                               mosi;
   logic                               ss_n;
   logic                               miso;
   logic [3:0]                         mapper;
   logic [mcu_cmd_pkg::addr_width-1:0] rom_mask;
   logic [mcu_cmd_pkg::addr_width-1:0] save_mask;
   logic [mcu_cmd_pkg::addr_width-1:0] mem_addr;

   spi_pkg::spi_byte_t tx_buf [16];
   spi_pkg::spi_byte_t rx_buf [16];
   logic [31:0]        rng_state;
   int                 errors;
   int                 checks;

   // Deeper than the 0xFF save mask, so the fold test sees address bit 8
   cart_ctrl_top #(
      .ADDR_WIDTH (mcu_cmd_pkg::addr_width),
      .DEPTH_LOG2 (10)
   ) i_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .sck       (sck),
      .mosi      (mosi),
      .ss_n      (ss_n),
      .miso      (miso),
      .mapper    (mapper),
      .rom_mask  (rom_mask),
      .save_mask (save_mask),
      .mem_addr  (mem_addr)
   );

   always #5 clk = ~clk;

   //////////////////////////////////////////////////
   // Random data and compare tasks
   //////////////////////////////////////////////////
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic spi_pkg::spi_byte_t rand_byte();
      rng_state = xorshift(rng_state);
      return rng_state[7:0];
   endfunction

   task automatic check_byte(input spi_pkg::spi_byte_t got, input spi_pkg::spi_byte_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_word(input logic [mcu_cmd_pkg::addr_width-1:0] got,
                             input logic [mcu_cmd_pkg::addr_width-1:0] exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_nibble(input logic [3:0] got, input logic [3:0] exp,
                               input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   //////////////////////////////////////////////////
   // SPI master, mode 0, MSB first
   //////////////////////////////////////////////////
   task automatic spi_xfer(input int n);
      spi_pkg::spi_byte_t rx;
      @(negedge clk);
      ss_n = 1'b0;
      for (int i = 0; i < n; i++) begin
         for (int b = 7; b >= 0; b--) begin
            mosi = tx_buf[i][b];
            repeat (half_cycles) @(negedge clk);
            sck   = 1'b1;
            rx[b] = miso;
            repeat (half_cycles) @(negedge clk);
            sck = 1'b0;
         end
         rx_buf[i] = rx;
      end
      repeat (half_cycles) @(negedge clk);
      ss_n = 1'b1;
      mosi = 1'b0;
      // Gap lets the last strobe settle
      repeat (2 * half_cycles) @(negedge clk);
   endtask

   // Command byte plus three bytes of a word, top byte first
   task automatic send_word_cmd(input mcu_cmd_pkg::cmd_op_e op,
                                input logic [mcu_cmd_pkg::addr_width-1:0] value);
      tx_buf[0] = {op, 4'h0};
      tx_buf[1] = value[23:16];
      tx_buf[2] = value[15:8];
      tx_buf[3] = value[7:0];
      spi_xfer(4);
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////
   task automatic test_reset_values();
      check_nibble(mapper, 4'h0, "mapper after reset");
      check_word(rom_mask, 24'hFF_FFFF, "rom_mask after reset");
      check_word(save_mask, 24'hFF_FFFF, "save_mask after reset");
      check_word(mem_addr, 24'h00_0000, "mem_addr after reset");
   endtask

   task automatic test_config_regs();
      spi_pkg::spi_byte_t                 b;
      logic [mcu_cmd_pkg::addr_width-1:0] word;
      b = rand_byte();
      tx_buf[0] = {mcu_cmd_pkg::set_mapper, b[3:0]};
      spi_xfer(1);
      check_nibble(mapper, b[3:0], "mapper");
      word = {rand_byte(), rand_byte(), rand_byte()};
      send_word_cmd(mcu_cmd_pkg::set_rom_mask, word);
      check_word(rom_mask, word, "rom_mask");
      word = {rand_byte(), rand_byte(), rand_byte()};
      send_word_cmd(mcu_cmd_pkg::set_save_mask, word);
      check_word(save_mask, word, "save_mask");
      // Open the save area again for the memory tests
      send_word_cmd(mcu_cmd_pkg::set_save_mask, 24'hFF_FFFF);
      check_word(save_mask, 24'hFF_FFFF, "save_mask restored");
   endtask

   task automatic test_addr_echo();
      logic [mcu_cmd_pkg::addr_width-1:0] addr;
      addr = {rand_byte(), rand_byte(), rand_byte()};
      send_word_cmd(mcu_cmd_pkg::set_addr, addr);
      check_word(mem_addr, addr, "mem_addr after set_addr");
      tx_buf[0] = {mcu_cmd_pkg::echo, 4'h0};
      for (int i = 1; i < 4; i++) begin
         tx_buf[i] = rand_byte();
      end
      spi_xfer(4);
      for (int i = 1; i < 4; i++) begin
         check_byte(rx_buf[i], 8'hA5, "echo reply");
      end
   endtask

   task automatic test_auto_inc();
      spi_pkg::spi_byte_t                 data [n_words];
      logic [mcu_cmd_pkg::addr_width-1:0] start;
      start = {16'h0000, rand_byte()};
      for (int i = 0; i < n_words; i++) begin
         data[i] = rand_byte();
      end
      send_word_cmd(mcu_cmd_pkg::set_addr, start);
      tx_buf[0] = {mcu_cmd_pkg::mem_write, 4'h1};
      for (int i = 0; i < n_words; i++) begin
         tx_buf[i + 1] = data[i];
      end
      spi_xfer(n_words + 1);
      check_word(mem_addr, start + n_words, "mem_addr after write burst");
      send_word_cmd(mcu_cmd_pkg::set_addr, start);
      tx_buf[0] = {mcu_cmd_pkg::mem_read, 4'h1};
      for (int i = 0; i < n_words; i++) begin
         tx_buf[i + 1] = 8'h00;
      end
      spi_xfer(n_words + 1);
      for (int i = 0; i < n_words; i++) begin
         check_byte(rx_buf[i + 1], data[i], "read burst data");
      end
      // The command byte starts a read as well
      check_word(mem_addr, start + n_words + 1, "mem_addr after read burst");
   endtask

   task automatic test_save_mask_fold();
      spi_pkg::spi_byte_t d;
      d = rand_byte();
      send_word_cmd(mcu_cmd_pkg::set_save_mask, 24'h00_00FF);
      send_word_cmd(mcu_cmd_pkg::set_addr, 24'h00_0123);
      tx_buf[0] = {mcu_cmd_pkg::mem_write, 4'h0};
      tx_buf[1] = d;
      spi_xfer(2);
      send_word_cmd(mcu_cmd_pkg::set_addr, 24'h00_0023);
      tx_buf[0] = {mcu_cmd_pkg::mem_read, 4'h0};
      tx_buf[1] = 8'h00;
      spi_xfer(2);
      check_byte(rx_buf[1], d, "read through save_mask");
      send_word_cmd(mcu_cmd_pkg::set_save_mask, 24'hFF_FFFF);
   endtask

   task automatic test_no_increment();
      spi_pkg::spi_byte_t                 d;
      logic [mcu_cmd_pkg::addr_width-1:0] addr;
      d    = rand_byte();
      addr = {16'h0000, rand_byte()};
      send_word_cmd(mcu_cmd_pkg::set_addr, addr);
      tx_buf[0] = {mcu_cmd_pkg::mem_write, 4'h0};
      tx_buf[1] = d;
      spi_xfer(2);
      check_word(mem_addr, addr, "mem_addr after plain write");
      tx_buf[0] = {mcu_cmd_pkg::mem_read, 4'h0};
      for (int i = 1; i < 4; i++) begin
         tx_buf[i] = 8'h00;
      end
      spi_xfer(4);
      for (int i = 1; i < 4; i++) begin
         check_byte(rx_buf[i], d, "repeated read");
      end
      check_word(mem_addr, addr, "mem_addr after plain read");
   endtask

   //////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////
   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      sck       = 1'b0;
      mosi      = 1'b0;
      ss_n      = 1'b1;
      rng_state = 32'd26;
      errors    = 0;
      checks    = 0;
      repeat (8) @(negedge clk);
      arst_n = 1'b1;
      repeat (2) @(negedge clk);
      test_reset_values();
      test_config_regs();
      test_addr_echo();
      test_auto_inc();
      test_save_mask_fold();
      test_no_increment();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(timeout_cycles * 10);
      $display("Watchdog expired: the tests did not finish in time");
      $display("Test failures found");
      $finish;
   end

endmodule
